/* verilog/uopPkg.sv */
package uopPkg;

    typedef enum logic [1:0] {
        FU_INT,
        FU_BRANCH,
        FU_BITMANIP
    } FuncUnit;

    typedef enum logic [4:0] {
        INT_ADD, INT_SUB, INT_XOR, INT_OR,
        INT_AND, INT_SLL, INT_SRL, INT_SRA,
        INT_SLT, INT_SLTU, INT_MIN, INT_MINU,
        INT_MAX, INT_MAXU, INT_LUI, INT_SH1ADD,
        INT_SH2ADD, INT_SH3ADD, INT_ANDN, INT_ORN,
        INT_XNOR, INT_SE_B, INT_SE_H, INT_ZE_H
    } IntOp;

    typedef enum logic [4:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR,
        BR_JR, BR_AUIPC
    } BranchOp;

    typedef enum logic [4:0] {
        BM_CLZ, BM_CTZ, BM_CPOP, BM_ROL,
        BM_ROR, BM_ORC_B, BM_REV8, BM_BCLR,
        BM_BEXT, BM_BINV, BM_BSET
    } BitOp;

    // one opcode word, read according to the functional unit.
    typedef union packed {
        IntOp intOp;
        BranchOp brOp;
        BitOp bitOp;
    } OpField;

    function automatic logic isCondBranch(BranchOp op);
        return op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    endfunction

    // actual outcome of a conditional branch.
    function automatic logic condTaken(BranchOp op, logic [31:0] a, logic [31:0] b);
        logic taken;
        case (op)
            BR_BEQ: taken = (a == b);
            BR_BNE: taken = (a != b);
            BR_BLT: taken = ($signed(a) < $signed(b));
            BR_BGE: taken = !($signed(a) < $signed(b));
            BR_BLTU: taken = (a < b);
            BR_BGEU: taken = !(a < b);
            default: taken = 1'b0;
        endcase
        return taken;
    endfunction

endpackage

/* verilog/flowPkg.sv */
package flowPkg;

    localparam int SEQ_W = 7;
    typedef logic [SEQ_W-1:0] SeqNum;

    // top tag bit set means no register write.
    localparam int TAG_W = 6;
    typedef logic [TAG_W-1:0] Tag;

    typedef enum logic [1:0] {
        FLAGS_NONE,
        FLAGS_PRED_TAKEN,
        FLAGS_PRED_NTAKEN,
        FLAGS_BRANCH
    } ResFlags;

    typedef enum logic [1:0] {
        CAUSE_BRANCH_TK,
        CAUSE_BRANCH_NT,
        CAUSE_IBRANCH
    } RedirCause;

endpackage

/* verilog/bitCount.sv */
module bitCount (
    input  logic [31:0] word,
    input  logic trailing,
    output logic [5:0] zeroCount,
    output logic [5:0] popCount
);

    logic [31:0] scanWord;

    // trailing count is a leading count of the reversed word.
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            scanWord[i] = trailing ? word[31-i] : word[i];
        end
    end

    always_comb begin
        zeroCount = 6'd32; // all zero.
        for (int i = 0; i < 32; i++) begin
            if (scanWord[i]) begin
                zeroCount = 6'(31 - i); // highest set bit wins.
            end
        end
    end

    always_comb begin
        popCount = '0;
        for (int i = 0; i < 32; i++) begin
            popCount = popCount + {5'b0, word[i]};
        end
    end

endmodule

/* verilog/uopLatch.sv */
module uopLatch (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  uopPkg::FuncUnit inFu,
    input  uopPkg::OpField inOp,
    input  logic [31:0] inSrcA,
    input  logic [31:0] inSrcB,
    input  logic [31:0] inImm,
    input  logic [31:0] inPc,
    input  logic inCompressed,
    input  flowPkg::SeqNum inSqN,
    input  flowPkg::Tag inTag,
    input  logic inPredTaken,
    input  logic flushValid,
    input  flowPkg::SeqNum flushSqN,
    input  logic redirValid,
    input  flowPkg::SeqNum redirSqN,
    output logic s1Valid,
    output uopPkg::FuncUnit s1Fu,
    output uopPkg::OpField s1Op,
    output logic [31:0] s1SrcA,
    output logic [31:0] s1SrcB,
    output logic [31:0] s1Imm,
    output logic [31:0] s1Pc,
    output logic s1Compressed,
    output flowPkg::SeqNum s1SqN,
    output flowPkg::Tag s1Tag,
    output logic s1PredTaken
);
    import flowPkg::*;

    logic heldValid;
    logic inKilled;
    logic heldKilled;

    // wrap-aware, a is younger when a - b is positive.
    function automatic logic younger(SeqNum a, SeqNum b);
        SeqNum diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    assign inKilled = (flushValid && younger(inSqN, flushSqN))
                   || (redirValid && younger(inSqN, redirSqN));
    assign heldKilled = (flushValid && younger(s1SqN, flushSqN))
                     || (redirValid && younger(s1SqN, redirSqN));

    assign s1Valid = heldValid && !heldKilled;

    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
        end else begin
            heldValid <= inValid && !inKilled;
        end
    end

    always_ff @(posedge clk) begin
        s1Fu <= inFu;
        s1Op <= inOp;
        s1SrcA <= inSrcA;
        s1SrcB <= inSrcB;
        s1Imm <= inImm;
        s1Pc <= inPc;
        s1Compressed <= inCompressed;
        s1SqN <= inSqN;
        s1Tag <= inTag;
        s1PredTaken <= inPredTaken;
    end

    ////////////////////////////////////////
    // a redirect comes from the micro-op that stood valid in stage 1 one cycle before.
    assert property (@(posedge clk) disable iff (rst)
        redirValid |-> $past(s1Valid) && (redirSqN == $past(s1SqN)));

endmodule

/* verilog/aluCore.sv */
module aluCore #(
    parameter bit enableBitmanip = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic s1Valid,
    input  uopPkg::FuncUnit s1Fu,
    input  uopPkg::OpField s1Op,
    input  logic [31:0] s1SrcA,
    input  logic [31:0] s1SrcB,
    input  logic [31:0] s1Imm,
    input  logic [31:0] s1Pc,
    input  logic s1Compressed,
    input  flowPkg::SeqNum s1SqN,
    input  flowPkg::Tag s1Tag,
    output logic resValid,
    output logic [31:0] resData,
    output flowPkg::Tag resTag,
    output flowPkg::SeqNum resSqN,
    output flowPkg::ResFlags resFlags
);
    import uopPkg::*;
    import flowPkg::*;

    logic [31:0] resC;
    ResFlags flagsC;
    logic unitOn;
    logic [5:0] zeroCount;
    logic [5:0] popCount;
    logic lessThan;
    logic lessThanU;
    logic [4:0] shamt;
    logic [31:0] bitMask;
    logic [63:0] rotLeft;
    logic [63:0] rotRight;
    logic [31:0] nextPc;
    logic [31:0] firstHalfPc;

    bitCount counter (
        .word(s1SrcA),
        .trailing(s1Op.bitOp == BM_CTZ),
        .zeroCount(zeroCount),
        .popCount(popCount)
    );

    assign lessThan = ($signed(s1SrcA) < $signed(s1SrcB));
    assign lessThanU = (s1SrcA < s1SrcB);
    assign shamt = s1SrcB[4:0];
    assign bitMask = 32'd1 << shamt;
    assign rotLeft = {s1SrcA, s1SrcA} << shamt;
    assign rotRight = {s1SrcA, s1SrcA} >> shamt;

    // s1Pc is the last halfword of the instruction.
    assign nextPc = s1Pc + 32'd2;
    assign firstHalfPc = s1Compressed ? s1Pc : s1Pc - 32'd2;

    ////////////////////////////////////////
    always_comb begin
        resC = '0;
        case (s1Fu)
            FU_INT: begin
                case (s1Op.intOp)
                    INT_ADD: resC = s1SrcA + s1SrcB;
                    INT_SUB: resC = s1SrcA - s1SrcB;
                    INT_XOR: resC = s1SrcA ^ s1SrcB;
                    INT_OR: resC = s1SrcA | s1SrcB;
                    INT_AND: resC = s1SrcA & s1SrcB;
                    INT_SLL: resC = s1SrcA << shamt;
                    INT_SRL: resC = s1SrcA >> shamt;
                    INT_SRA: resC = $signed(s1SrcA) >>> shamt;
                    INT_SLT: resC = {31'b0, lessThan};
                    INT_SLTU: resC = {31'b0, lessThanU};
                    INT_MIN: resC = lessThan ? s1SrcA : s1SrcB;
                    INT_MINU: resC = lessThanU ? s1SrcA : s1SrcB;
                    INT_MAX: resC = lessThan ? s1SrcB : s1SrcA;
                    INT_MAXU: resC = lessThanU ? s1SrcB : s1SrcA;
                    INT_LUI: resC = s1SrcB; // upper immediate arrives as srcB.
                    INT_SH1ADD: resC = s1SrcB + (s1SrcA << 1);
                    INT_SH2ADD: resC = s1SrcB + (s1SrcA << 2);
                    INT_SH3ADD: resC = s1SrcB + (s1SrcA << 3);
                    INT_ANDN: resC = s1SrcA & ~s1SrcB;
                    INT_ORN: resC = s1SrcA | ~s1SrcB;
                    INT_XNOR: resC = s1SrcA ^ ~s1SrcB;
                    INT_SE_B: resC = {{24{s1SrcA[7]}}, s1SrcA[7:0]};
                    INT_SE_H: resC = {{16{s1SrcA[15]}}, s1SrcA[15:0]};
                    INT_ZE_H: resC = {16'b0, s1SrcA[15:0]};
                    default: resC = '0;
                endcase
            end
            FU_BRANCH: begin
                // everything but AUIPC returns the link value.
                resC = (s1Op.brOp == BR_AUIPC) ? firstHalfPc + s1Imm : nextPc;
            end
            FU_BITMANIP: begin
                if (enableBitmanip) begin
                    case (s1Op.bitOp)
                        BM_CLZ, BM_CTZ: resC = {26'b0, zeroCount};
                        BM_CPOP: resC = {26'b0, popCount};
                        BM_ROL: resC = rotLeft[63:32];
                        BM_ROR: resC = rotRight[31:0];
                        BM_ORC_B: resC = {{8{|s1SrcA[31:24]}}, {8{|s1SrcA[23:16]}},
                                          {8{|s1SrcA[15:8]}}, {8{|s1SrcA[7:0]}}};
                        BM_REV8: resC = {s1SrcA[7:0], s1SrcA[15:8],
                                         s1SrcA[23:16], s1SrcA[31:24]};
                        BM_BCLR: resC = s1SrcA & ~bitMask;
                        BM_BEXT: resC = {31'b0, s1SrcA[shamt]};
                        BM_BINV: resC = s1SrcA ^ bitMask;
                        BM_BSET: resC = s1SrcA | bitMask;
                        default: resC = '0;
                    endcase
                end
            end
            default: resC = '0;
        endcase
    end

    always_comb begin
        flagsC = FLAGS_NONE;
        if (s1Fu == FU_BRANCH) begin
            if (isCondBranch(s1Op.brOp)) begin
                flagsC = condTaken(s1Op.brOp, s1SrcA, s1SrcB) ? FLAGS_PRED_TAKEN
                                                               : FLAGS_PRED_NTAKEN;
            end else if (s1Op.brOp inside {BR_JALR, BR_JR}) begin
                flagsC = FLAGS_BRANCH;
            end
        end
    end

    always_comb begin
        case (s1Fu)
            FU_INT, FU_BRANCH: unitOn = 1'b1;
            FU_BITMANIP: unitOn = enableBitmanip;
            default: unitOn = 1'b0; // unused code.
        endcase
    end

    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= s1Valid && unitOn;
        end
    end

    always_ff @(posedge clk) begin
        resData <= resC;
        resTag <= s1Tag;
        resSqN <= s1SqN;
        resFlags <= flagsC;
    end

    // operands come from outside the pipe, so check the whole path.
    assert property (@(posedge clk) disable iff (rst)
        resValid |-> !$isunknown(resData));

endmodule

/* verilog/branchUnit.sv */
module branchUnit (
    input  logic clk,
    input  logic rst,
    input  logic s1Valid,
    input  uopPkg::FuncUnit s1Fu,
    input  uopPkg::OpField s1Op,
    input  logic [31:0] s1SrcA,
    input  logic [31:0] s1SrcB,
    input  logic [31:0] s1Imm,
    input  logic [31:0] s1Pc,
    input  logic s1Compressed,
    input  flowPkg::SeqNum s1SqN,
    input  logic s1PredTaken,
    output logic redirValid,
    output logic [31:0] redirPc,
    output flowPkg::SeqNum redirSqN,
    output flowPkg::RedirCause redirCause
);
    import uopPkg::*;
    import flowPkg::*;

    logic isCond;
    logic isIndirect;
    logic taken;
    logic [31:0] nextPc;
    logic [31:0] firstHalfPc;
    logic [31:0] indSum;
    logic [31:0] indTarget;
    logic indCorrect;
    logic mispredict;
    logic [31:0] targetC;
    RedirCause causeC;

    assign isCond = isCondBranch(s1Op.brOp);
    assign isIndirect = s1Op.brOp inside {BR_JALR, BR_JR};
    assign taken = condTaken(s1Op.brOp, s1SrcA, s1SrcB);

    assign nextPc = s1Pc + 32'd2;
    assign firstHalfPc = s1Compressed ? s1Pc : s1Pc - 32'd2;

    // srcB holds the predicted target of an indirect jump.
    assign indSum = s1SrcA + s1Imm;
    assign indTarget = {indSum[31:1], 1'b0};
    assign indCorrect = (indTarget[31:1] == s1SrcB[31:1]);

    ////////////////////////////////////////
    always_comb begin
        mispredict = 1'b0;
        targetC = nextPc;
        causeC = CAUSE_BRANCH_NT;
        if (s1Fu == FU_BRANCH) begin
            if (isCond) begin
                mispredict = (taken != s1PredTaken);
                targetC = taken ? firstHalfPc + s1Imm : nextPc;
                causeC = taken ? CAUSE_BRANCH_TK : CAUSE_BRANCH_NT;
            end else if (isIndirect) begin
                mispredict = !indCorrect || !s1PredTaken;
                targetC = indTarget;
                causeC = CAUSE_IBRANCH;
            end
            // JAL and AUIPC never redirect.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            redirValid <= 1'b0;
        end else begin
            redirValid <= s1Valid && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        redirPc <= targetC;
        redirSqN <= s1SqN;
        redirCause <= causeC;
    end

endmodule

/* verilog/execPipe.sv */
module execPipe #(
    parameter bit enableBitmanip = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  uopPkg::FuncUnit inFu,
    input  uopPkg::OpField inOp,
    input  logic [31:0] inSrcA,
    input  logic [31:0] inSrcB,
    input  logic [31:0] inImm,
    input  logic [31:0] inPc,
    input  logic inCompressed,
    input  flowPkg::SeqNum inSqN,
    input  flowPkg::Tag inTag,
    input  logic inPredTaken,
    input  logic flushValid,
    input  flowPkg::SeqNum flushSqN,
    output logic resValid,
    output logic [31:0] resData,
    output flowPkg::Tag resTag,
    output flowPkg::SeqNum resSqN,
    output flowPkg::ResFlags resFlags,
    output logic redirValid,
    output logic [31:0] redirPc,
    output flowPkg::SeqNum redirSqN,
    output flowPkg::RedirCause redirCause
);
    import uopPkg::*;
    import flowPkg::*;

    // stage 1 outputs.
    logic s1Valid;
    FuncUnit s1Fu;
    OpField s1Op;
    logic [31:0] s1SrcA;
    logic [31:0] s1SrcB;
    logic [31:0] s1Imm;
    logic [31:0] s1Pc;
    logic s1Compressed;
    SeqNum s1SqN;
    Tag s1Tag;
    logic s1PredTaken;

    uopLatch latchStage (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inFu(inFu),
        .inOp(inOp),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inImm(inImm),
        .inPc(inPc),
        .inCompressed(inCompressed),
        .inSqN(inSqN),
        .inTag(inTag),
        .inPredTaken(inPredTaken),
        .flushValid(flushValid),
        .flushSqN(flushSqN),
        .redirValid(redirValid), // own redirect squashes younger uops.
        .redirSqN(redirSqN),
        .s1Valid(s1Valid),
        .s1Fu(s1Fu),
        .s1Op(s1Op),
        .s1SrcA(s1SrcA),
        .s1SrcB(s1SrcB),
        .s1Imm(s1Imm),
        .s1Pc(s1Pc),
        .s1Compressed(s1Compressed),
        .s1SqN(s1SqN),
        .s1Tag(s1Tag),
        .s1PredTaken(s1PredTaken)
    );

    ////////////////////////////////////////
    aluCore #(
        .enableBitmanip(enableBitmanip)
    ) alu (
        .clk(clk),
        .rst(rst),
        .s1Valid(s1Valid),
        .s1Fu(s1Fu),
        .s1Op(s1Op),
        .s1SrcA(s1SrcA),
        .s1SrcB(s1SrcB),
        .s1Imm(s1Imm),
        .s1Pc(s1Pc),
        .s1Compressed(s1Compressed),
        .s1SqN(s1SqN),
        .s1Tag(s1Tag),
        .resValid(resValid),
        .resData(resData),
        .resTag(resTag),
        .resSqN(resSqN),
        .resFlags(resFlags)
    );

    branchUnit branch (
        .clk(clk),
        .rst(rst),
        .s1Valid(s1Valid),
        .s1Fu(s1Fu),
        .s1Op(s1Op),
        .s1SrcA(s1SrcA),
        .s1SrcB(s1SrcB),
        .s1Imm(s1Imm),
        .s1Pc(s1Pc),
        .s1Compressed(s1Compressed),
        .s1SqN(s1SqN),
        .s1PredTaken(s1PredTaken),
        .redirValid(redirValid),
        .redirPc(redirPc),
        .redirSqN(redirSqN),
        .redirCause(redirCause)
    );

endmodule

/* bench/execRef.svh */
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// one issued micro-op as the model sees it.
typedef struct packed {
    FuncUnit fu;
    logic [4:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] pc;
    logic comp;
    SeqNum sqn;
    Tag tag;
    logic pred;
} Uop;

// fibonacci lfsr, taps 32 22 2 1.
function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// a is younger than b when a - b lies in the lower half of the ring.
function automatic logic isYounger(SeqNum a, SeqNum b);
    SeqNum d;
    d = a - b;
    return (d != '0) && !d[SEQ_W-1];
endfunction

function automatic logic condOp(Uop u);
    return BranchOp'(u.op) inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
endfunction

function automatic logic refTaken(Uop u);
    logic ltU;
    logic lt;
    logic t;
    ltU = u.a < u.b;
    lt = (u.a[31] != u.b[31]) ? u.a[31] : ltU; // sign bits differ, negative one is less.
    case (BranchOp'(u.op))
        BR_BEQ: t = (u.a == u.b);
        BR_BNE: t = (u.a != u.b);
        BR_BLT: t = lt;
        BR_BGE: t = !lt;
        BR_BLTU: t = ltU;
        BR_BGEU: t = !ltU;
        default: t = 1'b0;
    endcase
    return t;
endfunction

function automatic logic [31:0] countZeros(logic [31:0] w, logic fromLsb);
    logic [31:0] n;
    logic hit;
    n = 32'd0;
    hit = 1'b0;
    for (int i = 0; i < 32; i++) begin
        if (w[fromLsb ? i : 31 - i]) begin
            hit = 1'b1;
        end else if (!hit) begin
            n = n + 32'd1;
        end
    end
    return n;
endfunction

function automatic logic [31:0] refResult(Uop u);
    logic [31:0] r;
    logic [4:0] s;
    logic [31:0] oneBit;
    logic [31:0] firstHalf;
    s = u.b[4:0];
    oneBit = 32'd1 << s;
    firstHalf = u.comp ? u.pc : u.pc - 32'd2;
    r = 32'd0;
    if (u.fu == FU_INT) begin
        case (IntOp'(u.op))
            INT_ADD: r = u.a + u.b;
            INT_SUB: r = u.a - u.b;
            INT_XOR: r = u.a ^ u.b;
            INT_OR: r = u.a | u.b;
            INT_AND: r = u.a & u.b;
            INT_SLL: r = u.a << s;
            INT_SRL: r = u.a >> s;
            INT_SRA: r = $signed(u.a) >>> s;
            INT_SLT: r = {31'b0, $signed(u.a) < $signed(u.b)};
            INT_SLTU: r = {31'b0, u.a < u.b};
            INT_MIN: r = ($signed(u.a) < $signed(u.b)) ? u.a : u.b;
            INT_MINU: r = (u.a < u.b) ? u.a : u.b;
            INT_MAX: r = ($signed(u.a) > $signed(u.b)) ? u.a : u.b;
            INT_MAXU: r = (u.a > u.b) ? u.a : u.b;
            INT_LUI: r = u.b;
            INT_SH1ADD: r = (u.a << 1) + u.b;
            INT_SH2ADD: r = (u.a << 2) + u.b;
            INT_SH3ADD: r = (u.a << 3) + u.b;
            INT_ANDN: r = u.a & ~u.b;
            INT_ORN: r = u.a | ~u.b;
            INT_XNOR: r = ~(u.a ^ u.b);
            INT_SE_B: r = {{24{u.a[7]}}, u.a[7:0]};
            INT_SE_H: r = {{16{u.a[15]}}, u.a[15:0]};
            INT_ZE_H: r = {16'b0, u.a[15:0]};
            default: r = 32'd0;
        endcase
    end else if (u.fu == FU_BRANCH) begin
        r = (BranchOp'(u.op) == BR_AUIPC) ? firstHalf + u.imm : u.pc + 32'd2;
    end else if (u.fu == FU_BITMANIP) begin
        case (BitOp'(u.op))
            BM_CLZ: r = countZeros(u.a, 1'b0);
            BM_CTZ: r = countZeros(u.a, 1'b1);
            BM_CPOP: r = 32'($countones(u.a));
            BM_ROL: r = (s == 0) ? u.a : (u.a << s) | (u.a >> (6'd32 - {1'b0, s}));
            BM_ROR: r = (s == 0) ? u.a : (u.a >> s) | (u.a << (6'd32 - {1'b0, s}));
            BM_ORC_B: begin
                for (int i = 0; i < 4; i++) begin
                    r[8*i +: 8] = (u.a[8*i +: 8] != 8'd0) ? 8'hff : 8'h00;
                end
            end
            BM_REV8: begin
                for (int i = 0; i < 4; i++) begin
                    r[8*i +: 8] = u.a[8*(3-i) +: 8];
                end
            end
            BM_BCLR: r = u.a & ~oneBit;
            BM_BEXT: r = {31'b0, u.a[s]};
            BM_BINV: r = u.a ^ oneBit;
            BM_BSET: r = u.a | oneBit;
            default: r = 32'd0;
        endcase
    end
    return r;
endfunction

function automatic ResFlags refFlags(Uop u);
    ResFlags f;
    f = FLAGS_NONE;
    if (u.fu == FU_BRANCH && condOp(u)) begin
        f = refTaken(u) ? FLAGS_PRED_TAKEN : FLAGS_PRED_NTAKEN;
    end else if (u.fu == FU_BRANCH && BranchOp'(u.op) inside {BR_JALR, BR_JR}) begin
        f = FLAGS_BRANCH;
    end
    return f;
endfunction

// srcB carries the predicted target of an indirect jump.
function automatic void refRedirect(Uop u, output logic v, output logic [31:0] t,
                                    output RedirCause c);
    logic [31:0] ind;
    v = 1'b0;
    t = 32'd0;
    c = CAUSE_BRANCH_NT;
    ind = (u.a + u.imm) & ~32'd1;
    if (u.fu == FU_BRANCH && condOp(u)) begin
        v = (refTaken(u) != u.pred);
        t = refTaken(u) ? (u.comp ? u.pc : u.pc - 32'd2) + u.imm : u.pc + 32'd2;
        c = refTaken(u) ? CAUSE_BRANCH_TK : CAUSE_BRANCH_NT;
    end else if (u.fu == FU_BRANCH && BranchOp'(u.op) inside {BR_JALR, BR_JR}) begin
        v = (ind[31:1] != u.b[31:1]) || !u.pred;
        t = ind;
        c = CAUSE_IBRANCH;
    end
endfunction

`endif

/* bench/execPipeTb.sv */
module execPipeTb;
    import uopPkg::*;
    import flowPkg::*;

    `include "execRef.svh"

    localparam int PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INT = 200;
    localparam int NUM_BIT = 200;
    localparam int NUM_BR = 150;
    localparam int NUM_JMP = 150;
    localparam int NUM_DIRECTED = 18;
    localparam int NUM_UOPS = NUM_INT + NUM_BIT + NUM_BR + NUM_JMP + NUM_DIRECTED;

    // expected output of one cycle, checked at time due.
    typedef struct packed {
        logic [63:0] due;
        logic resV;
        logic [31:0] data;
        Tag tag;
        SeqNum sqn;
        ResFlags flags;
        logic redirV;
        logic [31:0] target;
        SeqNum redirSqN;
        RedirCause cause;
    } Expect;

    logic clk = 1'b0;
    logic rst;
    logic inValid;
    FuncUnit inFu;
    OpField inOp;
    logic [31:0] inSrcA;
    logic [31:0] inSrcB;
    logic [31:0] inImm;
    logic [31:0] inPc;
    logic inCompressed;
    SeqNum inSqN;
    Tag inTag;
    logic inPredTaken;
    logic flushValid;
    SeqNum flushSqN;
    logic resValid;
    logic [31:0] resData;
    Tag resTag;
    SeqNum resSqN;
    ResFlags resFlags;
    logic redirValid;
    logic [31:0] redirPc;
    SeqNum redirSqN;
    RedirCause redirCause;

    logic [31:0] lfsrState = 32'h4a521321;
    Expect expQ[$];
    Uop held = '0;
    logic heldV = 1'b0;
    logic expRedirV = 1'b0;
    SeqNum expRedirSqN = '0;
    SeqNum nextSqN = '0;
    int cycleCount = 0;
    int mismatches = 0;
    int pulseErrors = 0;

    execPipe #(.enableBitmanip(1'b1)) u_dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // drive one cycle and step the model past the next rising edge.
    task automatic driveCycle(input logic v, input Uop u, input logic fl, input SeqNum flSqN);
        Expect e;
        logic heldKill;
        logic inKill;
        logic rV;
        logic [31:0] rT;
        RedirCause rC;
        @(negedge clk);
        rst = (cycleCount < RESET_CYCLES - 1);
        cycleCount++;
        inValid = v;
        inFu = u.fu;
        inOp.intOp = IntOp'(u.op);
        inSrcA = u.a;
        inSrcB = u.b;
        inImm = u.imm;
        inPc = u.pc;
        inCompressed = u.comp;
        inSqN = u.sqn;
        inTag = u.tag;
        inPredTaken = u.pred;
        flushValid = fl;
        flushSqN = flSqN;
        heldKill = (fl && isYounger(held.sqn, flSqN))
                || (expRedirV && isYounger(held.sqn, expRedirSqN));
        inKill = (fl && isYounger(u.sqn, flSqN)) || (expRedirV && isYounger(u.sqn, expRedirSqN));
        e = '0;
        e.due = $time + PERIOD;
        if (!rst && heldV && !heldKill) begin
            refRedirect(held, rV, rT, rC);
            e.resV = 1'b1;
            e.data = refResult(held);
            e.tag = held.tag;
            e.sqn = held.sqn;
            e.flags = refFlags(held);
            e.redirV = rV;
            e.target = rT;
            e.redirSqN = held.sqn;
            e.cause = rC;
        end
        expQ.push_back(e);
        expRedirV = e.redirV;
        expRedirSqN = e.redirSqN;
        held = u;
        heldV = v && !inKill && !rst;
    endtask

    task automatic idleCycle();
        driveCycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic issueNext(input Uop u);
        Uop n;
        n = u;
        n.sqn = nextSqN;
        nextSqN = nextSqN + 1'b1;
        driveCycle(1'b1, n, 1'b0, '0);
    endtask

    task automatic randomUop(input FuncUnit fu, input int opBase, input int opCount,
                             output Uop u);
        logic [31:0] x;
        u = '0;
        u.fu = fu;
        u.op = 5'(opBase + randBits(5) % opCount);
        u.a = randBits(32);
        u.b = randBits(32);
        if (randBits(2) == 0) u.b = u.a; // equal operands now and then.
        x = randBits(12);
        u.imm = {{20{x[11]}}, x[11:0]};
        u.pc = randBits(31) << 1;
        u.comp = (randBits(1) != 0);
        u.tag = Tag'(randBits(6));
        u.pred = (randBits(1) != 0);
        if (fu == FU_BRANCH && randBits(1) != 0) begin
            u.b = ((u.a + u.imm) & ~32'd1) | randBits(1); // right target, bit 0 ignored.
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    always @(negedge clk) begin
        Expect e;
        if (expQ.size() > 0 && expQ[0].due <= $time) begin
            e = expQ.pop_front();
            if (resValid !== e.resV) begin
                pulseErrors++;
                if (e.resV) $display("missing result at time %0t for uop %0d", $time, e.sqn);
                else $display("unexpected result pulse at time %0t", $time);
            end else if (e.resV) begin
                checkValue("resData", resData, e.data);
                checkValue("resTag", 32'(resTag), 32'(e.tag));
                checkValue("resSqN", 32'(resSqN), 32'(e.sqn));
                checkValue("resFlags", 32'(resFlags), 32'(e.flags));
            end
            if (redirValid !== e.redirV) begin
                pulseErrors++;
                if (e.redirV) $display("missing redirect at time %0t for uop %0d", $time, e.sqn);
                else $display("unexpected redirect pulse at time %0t", $time);
            end else if (e.redirV) begin
                checkValue("redirPc", redirPc, e.target);
                checkValue("redirSqN", 32'(redirSqN), 32'(e.redirSqN));
                checkValue("redirCause", 32'(redirCause), 32'(e.cause));
            end
        end
    end

    initial begin
        #((NUM_UOPS * 8 + RESET_CYCLES + 20) * PERIOD);
        $display("watchdog timeout, the run did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        Uop u;
        SeqNum flushOrder[5];
        rst = 1'b1;
        inValid = 1'b0;
        inFu = FU_INT;
        inOp.intOp = INT_ADD;
        inSrcA = '0;
        inSrcB = '0;
        inImm = '0;
        inPc = '0;
        inCompressed = 1'b0;
        inSqN = '0;
        inTag = '0;
        inPredTaken = 1'b0;
        flushValid = 1'b0;
        flushSqN = '0;
        repeat (RESET_CYCLES + 2) idleCycle();

        repeat (NUM_INT) begin
            randomUop(FU_INT, 0, 24, u);
            issueNext(u);
        end

        // clz, ctz, cpop on all zero and all one, then rol, ror by 0 and 31.
        for (int i = 0; i < 5; i++) begin
            randomUop(FU_BITMANIP, i, 1, u);
            if (i < 3) u.a = 32'd0; else u.b = 32'd0;
            issueNext(u);
            if (i < 3) u.a = 32'hffffffff; else u.b = 32'd31;
            issueNext(u);
        end
        repeat (NUM_BIT) begin
            randomUop(FU_BITMANIP, 0, 11, u);
            issueNext(u);
        end
        repeat (NUM_BR) begin
            randomUop(FU_BRANCH, 0, 6, u);
            issueNext(u);
        end
        repeat (NUM_JMP) begin
            randomUop(FU_BRANCH, 6, 4, u); // jal, jalr, jr, auipc.
            issueNext(u);
        end

        // taken beq predicted not taken, then a younger and an older uop.
        repeat (2) idleCycle();
        randomUop(FU_BRANCH, 0, 1, u);
        u.b = u.a;
        u.pred = 1'b0;
        u.sqn = 7'd20;
        driveCycle(1'b1, u, 1'b0, '0);
        randomUop(FU_INT, 0, 24, u);
        u.sqn = 7'd21;
        driveCycle(1'b1, u, 1'b0, '0);
        u.sqn = 7'd18;
        driveCycle(1'b1, u, 1'b0, '0);

        // external flush at 126 for two cycles, uops issued out of order across the wrap.
        // held and incoming each meet it once as younger and once as older.
        flushOrder = '{7'd124, 7'd126, 7'd0, 7'd125, 7'd1};
        repeat (2) idleCycle();
        for (int i = 0; i < 5; i++) begin
            randomUop(FU_INT, 0, 24, u);
            u.sqn = flushOrder[i];
            driveCycle(1'b1, u, (i >= 3), 7'd126);
        end

        repeat (4) idleCycle();
        repeat (2) @(negedge clk);
        $display("errors: %0d mismatches, %0d pulse errors, %0d checks not done",
                 mismatches, pulseErrors, expQ.size());
        if (mismatches == 0 && pulseErrors == 0 && expQ.size() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* execPipe.f */
+incdir+bench
verilog/uopPkg.sv
verilog/flowPkg.sv
verilog/bitCount.sv
verilog/uopLatch.sv
verilog/aluCore.sv
verilog/branchUnit.sv
verilog/execPipe.sv
bench/execPipeTb.sv

/* run.sh */
#!/bin/bash
# build and run the execute pipeline testbench with verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    -f execPipe.f \
    --top-module execPipeTb \
    -Mdir obj_dir

./obj_dir/VexecPipeTb | tee sim.log

# the log decides pass or fail.
grep -q "TESTBENCH PASSED" sim.log
